// File: filelist.f
cpuPkg.sv
registerFile.sv
aluUnit.sv
hiLoUnit.sv
decodeStage.sv
executeStage.sv
cpuPipeline.sv
tb_cpuPipeline.sv

// File: Bender.yml
package:
  name: cpuPipeline

sources:
  - cpuPkg.sv
  - registerFile.sv
  - aluUnit.sv
  - hiLoUnit.sv
  - decodeStage.sv
  - executeStage.sv
  - cpuPipeline.sv
  - target: test
    files:
      - tb_cpuPipeline.sv

// File: cpuPatterns.txt
// valid instr expect wbAddr wbData test, all hex
// instr is {opcode, a1, a2, imm}, test numbers the behavior group
0 00000 0 0 0000 1 // idle after reset
1 01001 1 1 0000 1 // add r1 = r0 + r0
1 07015 1 1 0005 2 // addi r1 = r0 + 5
1 0702C 1 2 000C 2 // addi r2 = r0 + c, no sign extension
1 01123 1 3 0011 3 // add r3 = r1 + r2
1 02124 1 4 FFF9 3 // sub r4 = r1 - r2
1 03125 1 5 0004 3 // and r5
1 04126 1 6 000D 3 // or r6
1 05127 1 7 0009 3 // xor r7
1 06128 1 8 0001 3 // slt 5 < 12
1 06419 1 9 0001 3 // slt -7 < 5 signed
1 0614A 1 A 0000 3 // slt 5 < -7 signed
1 072B3 1 B 000F 4 // addi r11 = r2 + 3
1 01BBC 1 C 001E 4 // add r12 = r11 + r11, distance 1
1 02CBD 1 D 000F 4 // sub r13 = r12 - r11, distance 1 and 2
1 05BDE 1 E 0000 4 // xor r14 = r11 ^ r13
1 07FF7 1 F 0007 4 // addi r15 = r15 + 7
1 07FF9 1 F 0010 4 // addi r15 = r15 + 9, chained
1 01FD3 1 3 001F 4 // add r3 = r15 + r13, distance 1
1 04F15 1 5 0015 4 // or r5 = r15 | r1, distance 2
1 08420 0 0 0000 5 // mult r4 * r2, no writeback
1 09006 1 6 000B 5 // mfhi right behind mult
1 0A007 1 7 FFAC 5 // mflo
1 0708F 1 8 000F 5 // addi r8 = r0 + f
1 08870 0 0 0000 5 // mult r8 * r7, both forwarded
1 0A009 1 9 FB14 5 // mflo
1 0900A 1 A 000E 5 // mfhi
1 00121 0 0 0000 6 // nop aimed at r1
1 3F123 0 0 0000 6 // unknown opcode aimed at r3
1 0B124 0 0 0000 6 // unknown opcode aimed at r4
0 01125 0 0 0000 6 // add r5 with valid low
1 04101 1 1 0005 6 // r1 unchanged
1 01303 1 3 001F 6 // r3 unchanged
1 01404 1 4 FFF9 6 // r4 unchanged
1 01505 1 5 0015 6 // r5 unchanged
1 0900B 1 B 000E 6 // hi unchanged
0 00000 0 0 0000 6 // idle

// File: tb_cpuPipeline.sv
module tb_cpuPipeline;
	timeunit 1ns;
	timeprecision 1ps;

	import cpuPkg::*;

	localparam int dataWidth = 16;
	localparam int clkPeriod = 4;
	localparam int patCount = 37; // lines in the pattern file
	localparam int fieldCount = 6; // valid, instr, expect, addr, data, test

	logic clk, rst, instrValid;
	instr_t instr;
	logic wbValid;
	regAddr_t wbAddr;
	logic [dataWidth-1:0] wbData;

	logic [31:0] patMem [patCount*fieldCount]; // one word per field
	int cycleCount; // rising edges seen so far
	int dueQ[$]; // cycle in which each writeback must show up
	regAddr_t addrQ[$];
	logic [dataWidth-1:0] dataQ[$];
	int testQ[$];
	int mismatchCount, missingCount, extraCount;

	cpuPipeline #(.dataWidth(dataWidth)) cpuPipeline_i (
		.clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
		.wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
	);

	function automatic string testName(input int id);
		case (id)
			1: return "reset";
			2: return "addi";
			3: return "alu ops";
			4: return "forwarding";
			5: return "mult hi lo";
			6: return "no writeback";
			default: return "unnamed";
		endcase
	endfunction

	////////////////////
	// clock and cycle count
	////////////////////

	initial begin
		clk = 1'b0;
		forever #(clkPeriod/2) clk = ~clk;
	end

	always @(posedge clk) cycleCount <= cycleCount + 1;

	////////////////////
	// pattern driver
	////////////////////

	initial begin
		int base;
		int driveEdge;
		$readmemh("cpuPatterns.txt", patMem);
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		cycleCount = 0;
		mismatchCount = 0;
		missingCount = 0;
		extraCount = 0;
		repeat (2) @(posedge clk); // two reset cycles
		rst <= 1'b0;
		for (int p = 0; p < patCount; p++) begin
			@(posedge clk);
			base = p * fieldCount;
			instrValid <= patMem[base][0];
			instr <= patMem[base+1][instrWidth-1:0];
			if (patMem[base+2][0]) begin
				// cycleCount still holds the edge before this one
				driveEdge = cycleCount + 1; // edge that applies the instruction
				dueQ.push_back(driveEdge + 2); // decode and execute take a cycle each
				addrQ.push_back(patMem[base+3][regAddrWidth-1:0]);
				dataQ.push_back(patMem[base+4][dataWidth-1:0]);
				testQ.push_back(patMem[base+5]);
			end
		end
		@(posedge clk);
		instrValid <= 1'b0;
		while (dueQ.size() != 0) @(posedge clk); // drain the pipe
		repeat (2) @(posedge clk); // room for a stray late pulse
		$display("errors: %0d mismatched, %0d missing, %0d unexpected",
			mismatchCount, missingCount, extraCount);
		if (mismatchCount + missingCount + extraCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	////////////////////
	// writeback checker
	////////////////////

	// outputs move on the rising edge, so look mid cycle
	always @(negedge clk) begin
		if (!rst) begin
			if (dueQ.size() != 0 && dueQ[0] == cycleCount) begin
				if (wbValid !== 1'b1) begin
					missingCount++;
					$display("%s: no writeback in cycle %0d, r%0d was due",
						testName(testQ[0]), cycleCount, addrQ[0]);
				end else begin
					if (wbAddr !== addrQ[0]) begin
						mismatchCount++;
						$display("FAILED %s: wbAddr expected %0d actual %0d",
							testName(testQ[0]), addrQ[0], wbAddr);
					end
					if (wbData !== dataQ[0]) begin
						mismatchCount++;
						$display("FAILED %s: wbData expected %h actual %h",
							testName(testQ[0]), dataQ[0], wbData);
					end
				end
				void'(dueQ.pop_front());
				void'(addrQ.pop_front());
				void'(dataQ.pop_front());
				void'(testQ.pop_front());
			end else if (wbValid !== 1'b0) begin
				extraCount++; // nothing was scheduled for this cycle
				$display("writeback to r%0d with data %h came in cycle %0d with none expected",
					wbAddr, wbData, cycleCount);
			end
		end
	end

	////////////////////
	// watchdog
	////////////////////

	initial begin
		#((patCount + 10) * clkPeriod);
		$display("timeout, the run did not finish within %0d cycles", patCount + 10);
		$display("tests failed");
		$finish;
	end

endmodule

// File: cpuPipeline.sv
module cpuPipeline #(
	parameter int dataWidth = 16
) (
	input logic clk,
	input logic rst,
	input logic instrValid,
	input cpuPkg::instr_t instr,
	output logic wbValid,
	output cpuPkg::regAddr_t wbAddr,
	output logic [dataWidth-1:0] wbData
);
	import cpuPkg::*;

	////////////////////
	// decode to execute
	////////////////////

	logic exValid;
	logic [dataWidth-1:0] exRd1, exRd2;
	regAddr_t exA1, exA2;
	logic [dataWidth-1:0] exImm;
	regAddr_t exWriteAddr;
	logic exWriteEn;
	logic exAluSrc;
	aluOp_t exAluOp;
	resultSel_t exResultSel;
	logic exHiLoWe;

	// wb wires loop back into the register file write port
	decodeStage #(.dataWidth(dataWidth)) decodeStage_i (
		.clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
		.wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData),
		.exValid(exValid), .exRd1(exRd1), .exRd2(exRd2),
		.exA1(exA1), .exA2(exA2), .exImm(exImm),
		.exWriteAddr(exWriteAddr), .exWriteEn(exWriteEn),
		.exAluSrc(exAluSrc), .exAluOp(exAluOp),
		.exResultSel(exResultSel), .exHiLoWe(exHiLoWe)
	);

	executeStage #(.dataWidth(dataWidth)) executeStage_i (
		.clk(clk), .rst(rst),
		.exValid(exValid), .exRd1(exRd1), .exRd2(exRd2),
		.exA1(exA1), .exA2(exA2), .exImm(exImm),
		.exWriteAddr(exWriteAddr), .exWriteEn(exWriteEn),
		.exAluSrc(exAluSrc), .exAluOp(exAluOp),
		.exResultSel(exResultSel), .exHiLoWe(exHiLoWe),
		.wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
	);

endmodule

// File: executeStage.sv
module executeStage #(
	parameter int dataWidth = 16
) (
	input logic clk,
	input logic rst,
	input logic exValid,
	input logic [dataWidth-1:0] exRd1, // register file values
	input logic [dataWidth-1:0] exRd2,
	input cpuPkg::regAddr_t exA1,
	input cpuPkg::regAddr_t exA2,
	input logic [dataWidth-1:0] exImm,
	input cpuPkg::regAddr_t exWriteAddr,
	input logic exWriteEn,
	input logic exAluSrc,
	input cpuPkg::aluOp_t exAluOp,
	input cpuPkg::resultSel_t exResultSel,
	input logic exHiLoWe,
	output logic wbValid, // pulse per register write
	output cpuPkg::regAddr_t wbAddr,
	output logic [dataWidth-1:0] wbData
);
	import cpuPkg::*;

	logic [dataWidth-1:0] srcA, srcB; // forwarded operands
	logic [dataWidth-1:0] opB; // alu b after immediate mux
	logic [dataWidth-1:0] aluY;
	logic [dataWidth-1:0] hi, lo;
	logic [dataWidth-1:0] result;

	////////////////////
	// forwarding
	////////////////////

	// the instruction just ahead sits in the wb register and
	// has not reached the register file yet
	always_comb begin
		srcA = exRd1;
		srcB = exRd2;
		if (wbValid && (wbAddr == exA1)) srcA = wbData;
		if (wbValid && (wbAddr == exA2)) srcB = wbData;
	end

	assign opB = exAluSrc ? exImm : srcB; // addi takes the immediate

	aluUnit #(.dataWidth(dataWidth)) aluUnit_i (
		.a(srcA),
		.b(opB),
		.aluOp(exAluOp),
		.y(aluY)
	);

	// mult uses both register operands, never the immediate
	hiLoUnit #(.dataWidth(dataWidth)) hiLoUnit_i (
		.clk(clk),
		.rst(rst),
		.we(exHiLoWe),
		.a(srcA),
		.b(srcB),
		.hi(hi),
		.lo(lo)
	);

	////////////////////
	// result select
	////////////////////

	always_comb begin
		case (exResultSel)
			selHi: result = hi; // mfhi
			selLo: result = lo; // mflo
			default: result = aluY;
		endcase
	end

	////////////////////
	// execute/writeback register
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= exValid & exWriteEn; // mult and nop stay quiet
		end
	end

	always_ff @(posedge clk) begin
		wbAddr <= exWriteAddr;
		wbData <= result;
	end

endmodule

// File: decodeStage.sv
module decodeStage #(
	parameter int dataWidth = 16
) (
	input logic clk,
	input logic rst,
	input logic instrValid, // plain strobe, no back-pressure
	input cpuPkg::instr_t instr,
	input logic wbValid, // writeback feeds the register file
	input cpuPkg::regAddr_t wbAddr,
	input logic [dataWidth-1:0] wbData,
	output logic exValid,
	output logic [dataWidth-1:0] exRd1,
	output logic [dataWidth-1:0] exRd2,
	output cpuPkg::regAddr_t exA1, // source addresses for forwarding
	output cpuPkg::regAddr_t exA2,
	output logic [dataWidth-1:0] exImm,
	output cpuPkg::regAddr_t exWriteAddr,
	output logic exWriteEn,
	output logic exAluSrc, // 1 picks the immediate
	output cpuPkg::aluOp_t exAluOp,
	output cpuPkg::resultSel_t exResultSel,
	output logic exHiLoWe
);
	import cpuPkg::*;

	opcode_t opcode;
	regAddr_t a1F, a2F, immF; // instruction fields
	logic [dataWidth-1:0] rd1, rd2;
	aluOp_t aluOp;
	resultSel_t resultSel;
	logic aluSrc, writeEn, dstIsA2, hiLoWe;

	assign opcode = opcode_t'(instr[opcodeMsb:opcodeLsb]);
	assign a1F = instr[a1Msb:a1Lsb];
	assign a2F = instr[a2Msb:a2Lsb];
	assign immF = instr[immMsb:immLsb];

	registerFile #(.dataWidth(dataWidth)) registerFile_i (
		.clk(clk), .rst(rst),
		.ra1(a1F), .ra2(a2F), .rd1(rd1), .rd2(rd2),
		.we(wbValid), .wa(wbAddr), .wd(wbData)
	);

	////////////////////
	// opcode decode
	////////////////////

	always_comb begin
		aluOp = aluAdd;
		aluSrc = 1'b0;
		writeEn = 1'b0;
		dstIsA2 = 1'b0; // rr ops write the imm field register
		resultSel = selAlu;
		hiLoWe = 1'b0;
		case (opcode)
			opAdd: begin aluOp = aluAdd; writeEn = 1'b1; end
			opSub: begin aluOp = aluSub; writeEn = 1'b1; end
			opAnd: begin aluOp = aluAnd; writeEn = 1'b1; end
			opOr: begin aluOp = aluOr; writeEn = 1'b1; end
			opXor: begin aluOp = aluXor; writeEn = 1'b1; end
			opSlt: begin aluOp = aluSlt; writeEn = 1'b1; end
			opAddi: begin
				aluSrc = 1'b1; // b operand from immediate
				writeEn = 1'b1;
				dstIsA2 = 1'b1; // imm field is data here
			end
			opMult: hiLoWe = 1'b1; // only hi/lo change
			opMfhi: begin resultSel = selHi; writeEn = 1'b1; end
			opMflo: begin resultSel = selLo; writeEn = 1'b1; end
			default: ; // nop and unknown codes
		endcase
	end

	////////////////////
	// decode/execute register
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			exValid <= 1'b0;
			exWriteEn <= 1'b0;
			exHiLoWe <= 1'b0;
		end else begin
			exValid <= instrValid;
			exWriteEn <= instrValid & writeEn; // idle cycle writes nothing
			exHiLoWe <= instrValid & hiLoWe;
		end
	end

	// payload, only meaningful alongside the control bits
	always_ff @(posedge clk) begin
		exRd1 <= rd1;
		exRd2 <= rd2;
		exA1 <= a1F;
		exA2 <= a2F;
		exImm <= {{(dataWidth-regAddrWidth){1'b0}}, immF}; // zero extend
		exWriteAddr <= dstIsA2 ? a2F : immF;
		exAluSrc <= aluSrc;
		exAluOp <= aluOp;
		exResultSel <= resultSel;
	end

endmodule

// File: hiLoUnit.sv
module hiLoUnit #(
	parameter int dataWidth = 16
) (
	input logic clk,
	input logic rst,
	input logic we, // mult in execute
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	output logic [dataWidth-1:0] hi,
	output logic [dataWidth-1:0] lo
);

	logic [2*dataWidth-1:0] product; // full unsigned product

	assign product = a * b;

	////////////////////
	// hi and lo registers
	////////////////////

	// loaded at the edge ending the mult's execute cycle,
	// so a following mfhi/mflo already reads the new halves
	always_ff @(posedge clk) begin
		if (rst) begin
			hi <= '0;
			lo <= '0;
		end else if (we) begin
			hi <= product[2*dataWidth-1:dataWidth]; // upper half
			lo <= product[dataWidth-1:0]; // lower half
		end
	end

endmodule

// File: aluUnit.sv
module aluUnit #(
	parameter int dataWidth = 16
) (
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	input cpuPkg::aluOp_t aluOp,
	output logic [dataWidth-1:0] y
);
	import cpuPkg::*;

	logic less; // signed a < b

	assign less = $signed(a) < $signed(b);

	////////////////////
	// operation select
	////////////////////

	always_comb begin
		case (aluOp)
			aluAdd: begin
				y = a + b; // carry out dropped
			end
			aluSub: begin
				y = a - b;
			end
			aluAnd: begin
				y = a & b;
			end
			aluOr: begin
				y = a | b;
			end
			aluXor: begin
				y = a ^ b;
			end
			aluSlt: begin
				// result is a single bit, upper bits zero
				y = {{(dataWidth-1){1'b0}}, less};
			end
			default: begin
				y = '0; // unused encodings
			end
		endcase
	end

endmodule

// File: registerFile.sv
module registerFile #(
	parameter int dataWidth = 16
) (
	input logic clk,
	input logic rst,
	input cpuPkg::regAddr_t ra1, // read port 1 address
	input cpuPkg::regAddr_t ra2, // read port 2 address
	output logic [dataWidth-1:0] rd1,
	output logic [dataWidth-1:0] rd2,
	input logic we, // write enable from writeback
	input cpuPkg::regAddr_t wa,
	input logic [dataWidth-1:0] wd
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regs [regCount]; // 16 general purpose registers

	////////////////////
	// write port
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0; // everything reads zero after reset
			end
		end else if (we) begin
			regs[wa] <= wd;
		end
	end

	////////////////////
	// read ports
	////////////////////

	// write-through so an instruction two behind the writer
	// sees the value in the same cycle it is written
	always_comb begin
		rd1 = regs[ra1];
		rd2 = regs[ra2];
		if (we && (wa == ra1)) rd1 = wd; // bypass port 1
		if (we && (wa == ra2)) rd2 = wd; // bypass port 2
	end

endmodule

// File: cpuPkg.sv
package cpuPkg;

	////////////////////
	// instruction layout
	////////////////////

	localparam int instrWidth = 18; // one instruction word
	localparam int regAddrWidth = 4; // register address size
	localparam int regCount = 16; // register file depth

	// field positions inside the instruction word
	localparam int opcodeMsb = 17;
	localparam int opcodeLsb = 12;
	localparam int a1Msb = 11; // first source register
	localparam int a1Lsb = 8;
	localparam int a2Msb = 7; // second source, or addi destination
	localparam int a2Lsb = 4;
	localparam int immMsb = 3; // rr destination, or addi immediate
	localparam int immLsb = 0;

	typedef logic [instrWidth-1:0] instr_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;

	////////////////////
	// opcodes
	////////////////////

	// any code not listed here decodes as a nop
	typedef enum logic [5:0] {
		opNop = 6'h00,
		opAdd = 6'h01,
		opSub = 6'h02,
		opAnd = 6'h03,
		opOr = 6'h04,
		opXor = 6'h05,
		opSlt = 6'h06,
		opAddi = 6'h07, // rd in a2 field, imm zero extended
		opMult = 6'h08, // loads hi and lo, no gpr write
		opMfhi = 6'h09,
		opMflo = 6'h0A
	} opcode_t;

	// alu operation select
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr = 3'd3,
		aluXor = 3'd4,
		aluSlt = 3'd5 // signed compare
	} aluOp_t;

	// writeback value select
	typedef enum logic [1:0] {
		selAlu = 2'd0,
		selHi = 2'd1,
		selLo = 2'd2
	} resultSel_t;

endpackage
